// File: common/cache_geom_pkg.sv
// ******************************
// 16 lines of 4 words and a 10-bit word address
// addresses count words, not bytes
// ******************************
package cache_geom_pkg;

    localparam int word_bits   = 32;
    localparam int addr_bits   = 10;
    localparam int offset_bits = 2;
    localparam int index_bits  = 4;
    localparam int tag_bits    = 4;
    localparam int line_words  = 4;
    localparam int num_lines   = 16;
    localparam int mem_words   = 1 << addr_bits;

    // word position within a line
    typedef logic [offset_bits-1:0] word_sel_t;

    // tag in the top bits, word offset in the bottom two
    typedef struct packed {
        logic [tag_bits-1:0]    tag;
        logic [index_bits-1:0]  index;
        logic [offset_bits-1:0] offset;
    } addr_fields_t;

    // raw view for the memory, split view for the cache
    typedef union packed {
        logic [addr_bits-1:0] raw;
        addr_fields_t         fields;
    } word_addr_t;

endpackage

// File: common/cache_ctrl_pkg.sv
// ******************************
// controller states and burst limits
// ******************************
package cache_ctrl_pkg;

    typedef enum logic [2:0] {
        idle,
        lookup,
        writeback,
        refill,
        refill_wait,
        finish
    } ctrl_state_t;

    // final count of a one-line burst
    localparam cache_geom_pkg::word_sel_t burst_last =
        cache_geom_pkg::word_sel_t'(cache_geom_pkg::line_words - 1);

endpackage

// File: dcache/burst_counter.sv
// ******************************
// clear wins over step
// ******************************
`timescale 1ns/1ps

module burst_counter (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      burst_clear,
    input  logic                      burst_step,
    output cache_geom_pkg::word_sel_t count,
    output logic                      last
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else if (burst_clear) begin
            count <= '0;
        end else if (burst_step) begin
            // wraps to zero after the last word
            count <= count + cache_geom_pkg::word_sel_t'(1);
        end
    end

    assign last = (count == cache_ctrl_pkg::burst_last);

endmodule

// File: dcache/dcache_array.sv
// ******************************
// line becomes valid only when its last refill word lands
// ******************************
`timescale 1ns/1ps

module dcache_array (
    input  logic                                   clk,
    input  logic                                   arst_n,
    input  logic [cache_geom_pkg::index_bits-1:0]  index,
    input  logic [cache_geom_pkg::tag_bits-1:0]    tag,
    input  cache_geom_pkg::word_sel_t              offset,
    input  logic                                   lookup_en,
    input  logic                                   fill_en,
    input  cache_geom_pkg::word_sel_t              fill_word,
    input  logic [cache_geom_pkg::word_bits-1:0]   fill_data,
    input  logic                                   store_en,
    input  logic [cache_geom_pkg::word_bits-1:0]   store_data,
    input  cache_geom_pkg::word_sel_t              victim_word_sel,
    output logic                                   hit,
    output logic                                   victim_dirty,
    output logic [cache_geom_pkg::tag_bits-1:0]    victim_tag,
    output logic [cache_geom_pkg::word_bits-1:0]   word_out,
    output logic [cache_geom_pkg::word_bits-1:0]   line_word_out
);

    logic [cache_geom_pkg::word_bits-1:0] data_mem
        [cache_geom_pkg::num_lines][cache_geom_pkg::line_words];
    logic [cache_geom_pkg::tag_bits-1:0]  tag_mem [cache_geom_pkg::num_lines];
    logic [cache_geom_pkg::num_lines-1:0] valid;
    logic [cache_geom_pkg::num_lines-1:0] dirty;
    logic                                 fill_last;

    assign fill_last = fill_en && (fill_word == cache_ctrl_pkg::burst_last);

    always_ff @(posedge clk) begin
        if (fill_en) begin
            data_mem[index][fill_word] <= fill_data;
        end
        if (store_en) begin
            data_mem[index][offset] <= store_data;
        end
        if (fill_last) begin
            tag_mem[index] <= tag;
        end
        if (lookup_en) begin
            victim_tag <= tag_mem[index];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid        <= '0;
            dirty        <= '0;
            hit          <= 1'b0;
            victim_dirty <= 1'b0;
        end else begin
            if (fill_last) begin
                valid[index] <= 1'b1;
                dirty[index] <= 1'b0;
            end
            if (store_en) begin
                dirty[index] <= 1'b1;
            end
            if (lookup_en) begin
                hit          <= valid[index] && (tag_mem[index] == tag);
                victim_dirty <= valid[index] && dirty[index];
            end
        end
    end

    assign word_out      = data_mem[index][offset];
    assign line_word_out = data_mem[index][victim_word_sel];

endmodule

// File: dcache/dcache_fsm.sv
// ******************************
// one request at a time and req is ignored unless ready
// ******************************
`timescale 1ns/1ps

module dcache_fsm (
    input  logic                                      clk,
    input  logic                                      arst_n,
    input  logic                                      req,
    input  logic                                      we,
    input  cache_geom_pkg::word_addr_t                addr,
    input  logic [cache_geom_pkg::word_bits-1:0]      wdata,
    input  logic                                      hit,
    input  logic                                      victim_dirty,
    input  logic [cache_geom_pkg::tag_bits-1:0]       victim_tag,
    input  logic [cache_geom_pkg::word_bits-1:0]      word_in,
    input  logic [cache_geom_pkg::word_bits-1:0]      line_word_in,
    input  cache_geom_pkg::word_sel_t                 count,
    input  logic                                      last,
    input  logic [cache_geom_pkg::word_bits-1:0]      mem_rdata,
    output logic                                      ready,
    output logic                                      done,
    output logic                                      hit_out,
    output logic [cache_geom_pkg::word_bits-1:0]      rdata,
    output cache_geom_pkg::word_addr_t                cur_addr,
    output logic                                      lookup_en,
    output logic                                      fill_en,
    output cache_geom_pkg::word_sel_t                 fill_word,
    output logic [cache_geom_pkg::word_bits-1:0]      fill_data,
    output logic                                      store_en,
    output logic [cache_geom_pkg::word_bits-1:0]      store_data,
    output logic                                      burst_clear,
    output logic                                      burst_step,
    output logic                                      mem_we,
    output cache_geom_pkg::word_addr_t                mem_addr,
    output logic [cache_geom_pkg::word_bits-1:0]      mem_wdata
);

    cache_ctrl_pkg::ctrl_state_t            state;
    cache_ctrl_pkg::ctrl_state_t            state_next;
    cache_geom_pkg::word_addr_t             addr_q;
    logic [cache_geom_pkg::word_bits-1:0]   wdata_q;
    logic                                   we_q;
    logic                                   hit_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= cache_ctrl_pkg::idle;
            we_q  <= 1'b0;
            hit_q <= 1'b0;
        end else begin
            state <= state_next;
            if (lookup_en) begin
                we_q <= we;
            end
            if (state == cache_ctrl_pkg::lookup) begin
                hit_q <= hit;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_en) begin
            addr_q  <= addr;
            wdata_q <= wdata;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            cache_ctrl_pkg::idle: begin
                if (req) begin
                    state_next = cache_ctrl_pkg::lookup;
                end
            end
            cache_ctrl_pkg::lookup: begin
                if (hit) begin
                    state_next = cache_ctrl_pkg::finish;
                end else if (victim_dirty) begin
                    state_next = cache_ctrl_pkg::writeback;
                end else begin
                    state_next = cache_ctrl_pkg::refill;
                end
            end
            cache_ctrl_pkg::writeback: begin
                if (last) begin
                    state_next = cache_ctrl_pkg::refill;
                end
            end
            cache_ctrl_pkg::refill: begin
                if (last) begin
                    state_next = cache_ctrl_pkg::refill_wait;
                end
            end
            cache_ctrl_pkg::refill_wait: state_next = cache_ctrl_pkg::finish;
            default:                     state_next = cache_ctrl_pkg::idle;
        endcase
    end

    // array looks up the incoming address while idle and the held one after
    assign cur_addr  = (state == cache_ctrl_pkg::idle) ? addr : addr_q;
    assign ready     = (state == cache_ctrl_pkg::idle);
    assign lookup_en = ready && req;
    assign done      = (state == cache_ctrl_pkg::finish);
    assign hit_out   = hit_q;
    assign rdata     = we_q ? wdata_q : word_in;

    assign burst_clear = ((state == cache_ctrl_pkg::lookup) && !hit)
                       || ((state == cache_ctrl_pkg::writeback) && last);
    assign burst_step  = (state == cache_ctrl_pkg::writeback)
                       || (state == cache_ctrl_pkg::refill);

    // memory data trails its address by a cycle, so fill one word behind
    assign fill_en   = ((state == cache_ctrl_pkg::refill) && (count != '0))
                     || (state == cache_ctrl_pkg::refill_wait);
    assign fill_word = count - cache_geom_pkg::word_sel_t'(1);
    assign fill_data = mem_rdata;

    assign store_en   = done && we_q;
    assign store_data = wdata_q;

    assign mem_we    = (state == cache_ctrl_pkg::writeback);
    assign mem_wdata = line_word_in;

    always_comb begin
        mem_addr.fields.tag    = mem_we ? victim_tag : addr_q.fields.tag;
        mem_addr.fields.index  = addr_q.fields.index;
        mem_addr.fields.offset = count;
    end

endmodule

// File: src/backing_memory.sv
// ******************************
// read-first, one cycle read latency
// contents are undefined until written
// ******************************
`timescale 1ns/1ps

module backing_memory (
    input  logic                                  clk,
    input  logic                                  mem_we,
    input  logic [cache_geom_pkg::addr_bits-1:0]  mem_addr,
    input  logic [cache_geom_pkg::word_bits-1:0]  mem_wdata,
    output logic [cache_geom_pkg::word_bits-1:0]  mem_rdata
);

    logic [cache_geom_pkg::word_bits-1:0] ram [cache_geom_pkg::mem_words];

    always_ff @(posedge clk) begin
        if (mem_we) begin
            ram[mem_addr] <= mem_wdata;
        end
        mem_rdata <= ram[mem_addr];
    end

endmodule

// File: src/dcache_top.sv
// ******************************
// client waits for ready before each req
// done is a single-cycle pulse
// ******************************
`timescale 1ns/1ps

module dcache_top (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic                                  req,
    input  logic                                  we,
    input  cache_geom_pkg::word_addr_t            addr,
    input  logic [cache_geom_pkg::word_bits-1:0]  wdata,
    output logic                                  ready,
    output logic                                  done,
    output logic                                  hit,
    output logic [cache_geom_pkg::word_bits-1:0]  rdata
);

    cache_geom_pkg::word_addr_t            cur_addr;
    cache_geom_pkg::word_addr_t            mem_addr;
    cache_geom_pkg::word_sel_t             count;
    cache_geom_pkg::word_sel_t             fill_word;
    logic [cache_geom_pkg::tag_bits-1:0]   victim_tag;
    logic [cache_geom_pkg::word_bits-1:0]  word_out;
    logic [cache_geom_pkg::word_bits-1:0]  line_word_out;
    logic [cache_geom_pkg::word_bits-1:0]  fill_data;
    logic [cache_geom_pkg::word_bits-1:0]  store_data;
    logic [cache_geom_pkg::word_bits-1:0]  mem_wdata;
    logic [cache_geom_pkg::word_bits-1:0]  mem_rdata;
    logic                                  line_hit;
    logic                                  victim_dirty;
    logic                                  lookup_en;
    logic                                  fill_en;
    logic                                  store_en;
    logic                                  burst_clear;
    logic                                  burst_step;
    logic                                  last;
    logic                                  mem_we;

    dcache_fsm u_fsm (
        .clk          (clk),
        .arst_n       (arst_n),
        .req          (req),
        .we           (we),
        .addr         (addr),
        .wdata        (wdata),
        .hit          (line_hit),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .word_in      (word_out),
        .line_word_in (line_word_out),
        .count        (count),
        .last         (last),
        .mem_rdata    (mem_rdata),
        .ready        (ready),
        .done         (done),
        .hit_out      (hit),
        .rdata        (rdata),
        .cur_addr     (cur_addr),
        .lookup_en    (lookup_en),
        .fill_en      (fill_en),
        .fill_word    (fill_word),
        .fill_data    (fill_data),
        .store_en     (store_en),
        .store_data   (store_data),
        .burst_clear  (burst_clear),
        .burst_step   (burst_step),
        .mem_we       (mem_we),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata)
    );

    burst_counter u_counter (
        .clk         (clk),
        .arst_n      (arst_n),
        .burst_clear (burst_clear),
        .burst_step  (burst_step),
        .count       (count),
        .last        (last)
    );

    dcache_array u_array (
        .clk             (clk),
        .arst_n          (arst_n),
        .index           (cur_addr.fields.index),
        .tag             (cur_addr.fields.tag),
        .offset          (cur_addr.fields.offset),
        .lookup_en       (lookup_en),
        .fill_en         (fill_en),
        .fill_word       (fill_word),
        .fill_data       (fill_data),
        .store_en        (store_en),
        .store_data      (store_data),
        .victim_word_sel (count),
        .hit             (line_hit),
        .victim_dirty    (victim_dirty),
        .victim_tag      (victim_tag),
        .word_out        (word_out),
        .line_word_out   (line_word_out)
    );

    backing_memory u_memory (
        .clk       (clk),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr.raw),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

endmodule

// File: sim/tb_clock.sv
// ******************************
// 40 ns clock with reset lifted between edges
// ******************************
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic arst_n
);

    localparam int period_ns    = 40;
    localparam int reset_cycles = 5;

    initial begin
        clk = 1'b0;
        forever begin
            #(period_ns / 2);
            clk = ~clk;
        end
    end

    initial begin
        arst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        // release away from the rising edge
        #(period_ns / 4);
        arst_n = 1'b1;
    end

endmodule

// File: sim/dcache_checker.sv
// ******************************
// samples on the falling edge
// model covers a 128-word window only
// ******************************
`timescale 1ns/1ps

module dcache_checker (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic                                  req,
    input  logic                                  we,
    input  cache_geom_pkg::word_addr_t            addr,
    input  logic [cache_geom_pkg::word_bits-1:0]  wdata,
    input  logic                                  ready,
    input  logic                                  done,
    input  logic                                  hit,
    input  logic [cache_geom_pkg::word_bits-1:0]  rdata,
    output int                                    check_count,
    output int                                    error_count
);

    localparam int window_bits  = 7;
    localparam int window_words = 1 << window_bits;
    localparam int hit_latency  = 2;
    localparam int miss_limit   = 11;

    logic [cache_geom_pkg::word_bits-1:0] mem_image [window_words];
    logic [cache_geom_pkg::tag_bits-1:0]  tag_model [cache_geom_pkg::num_lines];
    logic [cache_geom_pkg::num_lines-1:0] valid_model;
    cache_geom_pkg::word_addr_t           exp_addr;
    logic [cache_geom_pkg::word_bits-1:0] exp_wdata;
    logic                                 exp_we;
    logic                                 exp_hit;
    logic                                 busy;
    int                                   cycles;

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Fail %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic report_problem(input string text);
        error_count++;
        $display("%s at %0t ns", text, $time);
    endtask

    task automatic start_access();
        exp_addr  = addr;
        exp_we    = we;
        exp_wdata = wdata;
        // hit when the line was seen before with the same tag
        exp_hit   = valid_model[addr.fields.index]
                  && (tag_model[addr.fields.index] == addr.fields.tag);
        valid_model[addr.fields.index] = 1'b1;
        tag_model[addr.fields.index]   = addr.fields.tag;
        busy   = 1'b1;
        cycles = 0;
    endtask

    task automatic finish_access();
        compare_value("hit_flag", 32'(exp_hit), 32'(hit));
        if (exp_hit) begin
            compare_value("hit_latency", hit_latency, cycles);
        end
        if (ready !== 1'b0) begin
            report_problem("ready was high while done pulsed");
        end
        if (exp_we) begin
            compare_value("write_echo", exp_wdata, rdata);
            mem_image[exp_addr.raw[window_bits-1:0]] = exp_wdata;
        end else begin
            compare_value("read_data", mem_image[exp_addr.raw[window_bits-1:0]], rdata);
        end
        busy = 1'b0;
    endtask

    always @(negedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_model = '0;
            busy        = 1'b0;
            cycles      = 0;
            check_count = 0;
            error_count = 0;
        end else begin
            if (busy) begin
                cycles++;
            end
            if (done === 1'b1) begin
                if (!busy) begin
                    report_problem("done pulsed with no request outstanding");
                end else begin
                    finish_access();
                end
            end else if (busy) begin
                if (ready !== 1'b0) begin
                    report_problem("ready was high while a request was in progress");
                end
                if (cycles >= miss_limit) begin
                    report_problem("request got no done within 11 cycles");
                    busy = 1'b0;
                end
            end else if (ready !== 1'b1) begin
                report_problem("ready was low while the cache was idle");
            end
            // a req while ready is low must be dropped
            if (!busy && (req === 1'b1) && (ready === 1'b1)) begin
                start_access();
            end
        end
    end

endmodule

// File: sim/dcache_tb.sv
// ******************************
// requests stay in a 128-word window with two tags per index
// ******************************
`timescale 1ns/1ps

module dcache_tb;

    localparam int          window_bits     = 7;
    localparam int          fill_words      = 1 << window_bits;
    localparam int          random_requests = 300;
    localparam int          timeout_cycles  = (fill_words + random_requests) * 11 + 100;
    localparam logic [15:0] lfsr_seed       = 16'd48;
    localparam logic [15:0] lfsr_taps       = 16'hB400;

    logic                                  clk;
    logic                                  arst_n;
    logic                                  req;
    logic                                  we;
    cache_geom_pkg::word_addr_t            addr;
    logic [cache_geom_pkg::word_bits-1:0]  wdata;
    logic                                  ready;
    logic                                  done;
    logic                                  hit;
    logic [cache_geom_pkg::word_bits-1:0]  rdata;
    logic [15:0]                           lfsr;
    int                                    check_count;
    int                                    error_count;
    int                                    cycle_count = 0;

    tb_clock u_clock (
        .clk    (clk),
        .arst_n (arst_n)
    );

    dcache_top DUT (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (req),
        .we     (we),
        .addr   (addr),
        .wdata  (wdata),
        .ready  (ready),
        .done   (done),
        .hit    (hit),
        .rdata  (rdata)
    );

    dcache_checker u_checker (
        .clk         (clk),
        .arst_n      (arst_n),
        .req         (req),
        .we          (we),
        .addr        (addr),
        .wdata       (wdata),
        .ready       (ready),
        .done        (done),
        .hit         (hit),
        .rdata       (rdata),
        .check_count (check_count),
        .error_count (error_count)
    );

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ lfsr_taps;
        end
        return s >> 1;
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits = {bits[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return bits;
    endfunction

    task automatic issue_request(input logic write, input logic [window_bits-1:0] word,
                                 input logic [31:0] data, input logic extra);
        @(posedge clk);
        #2;
        req   = 1'b1;
        we    = write;
        addr  = '0;
        addr.raw[window_bits-1:0] = word;
        wdata = data;
        @(posedge clk);
        #2;
        // second pulse lands while busy with the other tag and data
        req   = extra;
        we    = ~write;
        addr.raw[window_bits-1] = ~addr.raw[window_bits-1];
        wdata = ~data;
        @(posedge clk);
        #2;
        req = 1'b0;
        @(negedge clk);
        while (done !== 1'b1) begin
            @(negedge clk);
        end
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout after %0d cycles, the cache stopped responding", cycle_count);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        logic [31:0] choice;
        logic [31:0] word_sel;
        logic [31:0] data;
        req   = 1'b0;
        we    = 1'b0;
        addr  = '0;
        wdata = '0;
        lfsr  = lfsr_seed;
        wait (arst_n === 1'b1);
        // every word in the window gets a known value
        for (int a = 0; a < fill_words; a++) begin
            data = take_bits(32);
            issue_request(1'b1, a[window_bits-1:0], data, 1'b0);
        end
        for (int n = 0; n < random_requests; n++) begin
            choice   = take_bits(3);
            word_sel = take_bits(window_bits);
            data     = take_bits(32);
            issue_request(choice[0], word_sel[window_bits-1:0], data, choice[1] & choice[2]);
        end
        repeat (4) @(posedge clk);
        $display("checks %0d, errors %0d", check_count, error_count);
        if ((error_count == 0) && (check_count > 0)) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: dcache_top.f
common/cache_geom_pkg.sv
common/cache_ctrl_pkg.sv
dcache/burst_counter.sv
dcache/dcache_array.sv
dcache/dcache_fsm.sv
src/backing_memory.sv
src/dcache_top.sv
sim/tb_clock.sv
sim/dcache_checker.sv
sim/dcache_tb.sv

// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= dcache_top.f
TB_TOP    ?= dcache_tb
RTL_TOP   ?= dcache_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --timescale 1ns/1ps

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -qx 'No errors' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
